//--- jit_crossbar.f
+incdir+tb
verilog/xbar_stream_pkg.sv
verilog/xbar_conf_pkg.sv
verilog/conf_decoder.sv
verilog/source_fork.sv
verilog/sink_stage.sv
verilog/jit_crossbar.sv
tb/tb_jit_crossbar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator, run it and grade the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_jit_crossbar \
  -f jit_crossbar.f \
  --Mdir obj_dir \
  -o sim_jit_crossbar

./obj_dir/sim_jit_crossbar | tee "$LOG"

if grep -qx "All checks passed" "$LOG"; then
  echo "simulation result: PASS"
  exit 0
else
  echo "simulation result: FAIL"
  exit 1
fi

//--- tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int n_checks = 0;
int n_errors = 0;

// 32-bit xorshift with shifts 13, 17 and 5.
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

task automatic check_data(input string msg, input data_t got, input data_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERROR %0t: %s: got %h, expected %h", $time, msg, got, exp);
  end
endtask

task automatic check_mask(input string msg, input src_mask_t got, input src_mask_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERROR %0t: %s: got %b, expected %b", $time, msg, got, exp);
  end
endtask

task automatic check_bit(input string msg, input logic got, input logic exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERROR %0t: %s: got %b, expected %b", $time, msg, got, exp);
  end
endtask

`endif

//--- tb/tb_jit_crossbar.sv
`timescale 1ns/1ps

module tb_jit_crossbar
  import xbar_stream_pkg::*, xbar_conf_pkg::*;
();

  localparam int NUM_ROWS      = 7;
  localparam int MIN_CYCLES    = 8;    // keeps an all-idle row running a while.
  localparam int STALL_LEN     = 24;   // cycles of held-low tready in mode 2.
  localparam int TEST_TIMEOUT  = 2000;
  localparam int DRAIN_TIMEOUT = 32;

  logic                  aclk;
  logic                  arst_n;
  sel_t  [NUM_SINKS-1:0] conf_sel;
  src_mask_t             src_tvalid;
  src_mask_t             src_tready;
  data_t [NUM_ACCS-1:0]  src_tdata;
  sink_mask_t            snk_tvalid;
  sink_mask_t            snk_tready;
  data_t [NUM_SINKS-1:0] snk_tdata;

  `include "tb_checks.svh"

  // stall mode 0 keeps tready high, 1 toggles it randomly, 2 holds it low first.
  string row_name [NUM_ROWS] = '{
    "all idle", "permutation", "broadcast", "idle and out of range",
    "random stall", "broadcast random stall", "long stall"
  };

  sel_t row_sel [NUM_ROWS][NUM_SINKS] = '{
    '{4'd0, 4'd0, 4'd0,  4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
    '{4'd2, 4'd4, 4'd1,  4'd3, 4'd3, 4'd1, 4'd4, 4'd2},
    '{4'd3, 4'd1, 4'd3,  4'd0, 4'd0, 4'd3, 4'd0, 4'd3},
    '{4'd0, 4'd5, 4'd15, 4'd2, 4'd9, 4'd0, 4'd2, 4'd6},
    '{4'd1, 4'd2, 4'd3,  4'd4, 4'd4, 4'd3, 4'd2, 4'd1},
    '{4'd4, 4'd4, 4'd4,  4'd4, 4'd1, 4'd1, 4'd0, 4'd12},
    '{4'd2, 4'd2, 4'd1,  4'd0, 4'd3, 4'd0, 4'd4, 4'd4}
  };

  data_t row_base [NUM_ROWS][NUM_ACCS] = '{
    '{32'h1000_0000, 32'h2000_0000, 32'h3000_0000, 32'h4000_0000},
    '{32'ha000_0100, 32'hb000_0200, 32'hc000_0300, 32'hd000_0400},
    '{32'h0000_1111, 32'h0000_2222, 32'h0000_3333, 32'h0000_4444},
    '{32'h5a5a_0000, 32'h6b6b_0000, 32'h7c7c_0000, 32'h8d8d_0000},
    '{32'hdead_0000, 32'hbeef_0000, 32'hcafe_0000, 32'hf00d_0000},
    '{32'h0101_0000, 32'h0202_0000, 32'h0303_0000, 32'h0404_0000},
    '{32'h7000_0010, 32'h7100_0020, 32'h7200_0030, 32'h7300_0040}
  };

  int row_count [NUM_ROWS] = '{4, 12, 16, 10, 24, 20, 12};
  int row_mode  [NUM_ROWS] = '{0, 0, 0, 0, 1, 1, 2};

  logic [31:0] rng_state = 32'hcd814fb8;
  bit          timed_out = 1'b0;

  // per-row reference state.
  int         sent        [NUM_ACCS];
  int         recv        [NUM_SINKS];
  int         src_of_sink [NUM_SINKS];
  src_mask_t  has_user;

  jit_crossbar UUT (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .conf_sel   (conf_sel),
    .src_tvalid (src_tvalid),
    .src_tready (src_tready),
    .src_tdata  (src_tdata),
    .snk_tvalid (snk_tvalid),
    .snk_tready (snk_tready),
    .snk_tdata  (snk_tdata)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // code 1..NUM_ACCS names source code-1 and anything else is idle.
  function automatic int sel_source(input sel_t sel);
    int code;
    code = int'(sel);
    if (code >= 1 && code <= NUM_ACCS) begin
      return code - 1;
    end
    return -1;
  endfunction

  function automatic bit row_done(input int r);
    for (int a = 0; a < NUM_ACCS; a++) begin
      if (has_user[a] && sent[a] < row_count[r]) begin
        return 1'b0;
      end
    end
    for (int s = 0; s < NUM_SINKS; s++) begin
      if (src_of_sink[s] >= 0 && recv[s] < row_count[r]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drive_cycle(input int r, input int cyc, input bit drain);
    sink_mask_t rdy;
    @(posedge aclk);
    rng_state = xorshift32(rng_state);
    if (drain || row_mode[r] == 0) begin
      rdy = '1;
    end else if (row_mode[r] == 2 && cyc < STALL_LEN) begin
      rdy = '0;
    end else begin
      rdy = snk_tready ^ rng_state[NUM_SINKS-1:0];
    end
    snk_tready <= rdy;
    for (int a = 0; a < NUM_ACCS; a++) begin
      // unused sources stay valid so a stuck-high tready would show.
      if (!drain && (!has_user[a] || sent[a] < row_count[r])) begin
        src_tvalid[a] <= 1'b1;
        src_tdata[a]  <= row_base[r][a] + data_t'(sent[a]);
      end else begin
        src_tvalid[a] <= 1'b0;
      end
    end
  endtask

  // sampled mid-cycle while the values hold until the next rising edge.
  task automatic sample_cycle(input int r);
    src_mask_t  exp_ready;
    sink_mask_t held;
    int         src;
    @(negedge aclk);
    // a stage holds a beat that its source sent and the sink has not taken.
    for (int s = 0; s < NUM_SINKS; s++) begin
      held[s] = 1'b0;
      if (src_of_sink[s] >= 0) begin
        held[s] = sent[src_of_sink[s]] > recv[s];
      end
    end
    for (int a = 0; a < NUM_ACCS; a++) begin
      exp_ready[a] = has_user[a];
      for (int s = 0; s < NUM_SINKS; s++) begin
        if (src_of_sink[s] == a && held[s] && !snk_tready[s]) begin
          exp_ready[a] = 1'b0; // full and stalled.
        end
      end
    end
    check_mask("src_tready", src_tready, exp_ready);
    for (int s = 0; s < NUM_SINKS; s++) begin
      src = src_of_sink[s];
      if (src < 0) begin
        check_bit($sformatf("idle sink %0d tvalid", s), snk_tvalid[s], 1'b0);
      end else begin
        check_bit($sformatf("sink %0d tvalid", s), snk_tvalid[s], held[s]);
        if (snk_tvalid[s] && snk_tready[s]) begin
          if (recv[s] >= row_count[r]) begin
            check_bit($sformatf("extra beat on sink %0d", s), 1'b1, 1'b0);
          end else begin
            check_data($sformatf("sink %0d beat %0d", s, recv[s]), snk_tdata[s],
                       row_base[r][src] + data_t'(recv[s]));
            recv[s]++;
          end
        end
      end
    end
    for (int a = 0; a < NUM_ACCS; a++) begin
      if (src_tvalid[a] && src_tready[a]) begin
        sent[a]++;
      end
    end
  endtask

  task automatic run_test(input int r);
    int errs_before;
    int cyc;
    errs_before = n_errors;
    @(posedge aclk);
    for (int s = 0; s < NUM_SINKS; s++) begin
      conf_sel[s] <= row_sel[r][s];
    end
    src_tvalid <= '0;
    snk_tready <= '1;
    repeat (2) @(posedge aclk); // select register settles.

    has_user = '0;
    for (int a = 0; a < NUM_ACCS; a++) begin
      sent[a] = 0;
    end
    for (int s = 0; s < NUM_SINKS; s++) begin
      recv[s]        = 0;
      src_of_sink[s] = sel_source(row_sel[r][s]);
      if (src_of_sink[s] >= 0) begin
        has_user[src_of_sink[s]] = 1'b1;
      end
    end

    cyc = 0;
    while (!row_done(r) || cyc < MIN_CYCLES) begin
      if (cyc >= TEST_TIMEOUT) begin
        $display("timeout: test %0d (%s) still missing beats after %0d cycles",
                 r, row_name[r], cyc);
        timed_out = 1'b1;
        return;
      end
      drive_cycle(r, cyc, 1'b0);
      sample_cycle(r);
      cyc++;
    end

    // let the last beats leave and watch for anything extra.
    cyc = 0;
    do begin
      if (cyc >= DRAIN_TIMEOUT) begin
        $display("timeout: test %0d (%s) sinks still hold beats after the drain",
                 r, row_name[r]);
        timed_out = 1'b1;
        return;
      end
      drive_cycle(r, cyc, 1'b1);
      sample_cycle(r);
      cyc++;
    end while (snk_tvalid != '0 || cyc < 2);

    $display("test %0d %-24s %0d beats per source, %0d errors: %s", r, row_name[r],
             row_count[r], n_errors - errs_before,
             (n_errors == errs_before) ? "ok" : "MISMATCH");
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = n_errors;
    @(posedge aclk);
    src_tvalid <= '1;
    @(negedge aclk);
    for (int s = 0; s < NUM_SINKS; s++) begin
      check_bit($sformatf("sink %0d tvalid after reset", s), snk_tvalid[s], 1'b0);
    end
    check_mask("src_tready after reset", src_tready, '0);
    @(posedge aclk);
    src_tvalid <= '0;
    $display("reset state: %0d errors", n_errors - errs_before);
  endtask

  initial begin
    arst_n     <= 1'b0;
    conf_sel   <= '0;
    src_tvalid <= '0;
    src_tdata  <= '0;
    snk_tready <= '0;
    has_user    = '0;
    repeat (10) @(posedge aclk);
    arst_n <= 1'b1;

    check_reset_state();
    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      run_test(r);
    end

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (timed_out || n_errors != 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

//--- verilog/conf_decoder.sv
`timescale 1ns/1ps

module conf_decoder
  import xbar_stream_pkg::*, xbar_conf_pkg::*;
(
  input  logic                         aclk,
  input  logic                         arst_n,
  input  sel_t        [NUM_SINKS-1:0]  conf_sel,
  output src_onehot_t [NUM_SINKS-1:0]  sink_onehot,
  output sink_mask_t  [NUM_ACCS-1:0]   src_users
);

  sel_t [NUM_SINKS-1:0] sel_q;

  // selects are levels, sampled once per clock.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < NUM_SINKS; s++) begin
        sel_q[s] <= SEL_IDLE;
      end
    end else begin
      sel_q <= conf_sel;
    end
  end

  // code a+1 selects source a; idle and out-of-range codes match nothing.
  always_comb begin
    for (int s = 0; s < NUM_SINKS; s++) begin
      for (int a = 0; a < NUM_ACCS; a++) begin
        sink_onehot[s][a] = (sel_q[s] == sel_t'(a + 1));
      end
    end
  end

  // transpose to the set of sinks fed by each source.
  always_comb begin
    for (int a = 0; a < NUM_ACCS; a++) begin
      for (int s = 0; s < NUM_SINKS; s++) begin
        src_users[a][s] = sink_onehot[s][a];
      end
    end
  end

endmodule

//--- verilog/jit_crossbar.sv
`timescale 1ns/1ps

module jit_crossbar
  import xbar_stream_pkg::*, xbar_conf_pkg::*;
(
  input  logic                      aclk,
  input  logic                      arst_n,

  input  sel_t  [NUM_SINKS-1:0]     conf_sel,    // one select per sink.

  input  src_mask_t                 src_tvalid,  // result streams C.
  output src_mask_t                 src_tready,
  input  data_t [NUM_ACCS-1:0]      src_tdata,

  output sink_mask_t                snk_tvalid,  // operand streams A and B.
  input  sink_mask_t                snk_tready,
  output data_t [NUM_SINKS-1:0]     snk_tdata
);

  src_onehot_t [NUM_SINKS-1:0]  sink_onehot;
  sink_mask_t  [NUM_ACCS-1:0]   src_users;
  sink_mask_t                   space;
  src_mask_t                    src_fire;

  conf_decoder u_conf_decoder (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .conf_sel    (conf_sel),
    .sink_onehot (sink_onehot),
    .src_users   (src_users)
  );

  source_fork u_source_fork (
    .src_tvalid (src_tvalid),
    .src_users  (src_users),
    .space      (space),
    .src_tready (src_tready),
    .src_fire   (src_fire)
  );

  // one register slice per operand port.
  for (genvar s = 0; s < NUM_SINKS; s++) begin : g_sink
    sink_stage u_sink_stage (
      .aclk       (aclk),
      .arst_n     (arst_n),
      .onehot     (sink_onehot[s]),
      .src_fire   (src_fire),
      .src_tdata  (src_tdata),
      .space      (space[s]),
      .snk_tready (snk_tready[s]),
      .snk_tvalid (snk_tvalid[s]),
      .snk_tdata  (snk_tdata[s])
    );
  end

endmodule

//--- verilog/sink_stage.sv
`timescale 1ns/1ps

module sink_stage
  import xbar_stream_pkg::*, xbar_conf_pkg::*;
(
  input  logic                        aclk,
  input  logic                        arst_n,
  input  src_onehot_t                 onehot,
  input  src_mask_t                   src_fire,
  input  data_t       [NUM_ACCS-1:0]  src_tdata,
  output logic                        space,
  input  logic                        snk_tready,
  output logic                        snk_tvalid,
  output data_t                       snk_tdata
);

  logic   load;
  data_t  load_data;
  logic   vld_q;
  data_t  data_q;

  // one-hot and-or mux over the source beats.
  always_comb begin
    load_data = '0;
    for (int a = 0; a < NUM_ACCS; a++) begin
      load_data = load_data | (src_tdata[a] & {DATA_W{onehot[a]}});
    end
  end

  assign load  = |(onehot & src_fire);   // our source moved this cycle.
  assign space = !vld_q || snk_tready;   // empty, or draining now.

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
    end else if (load) begin
      vld_q <= 1'b1;
    end else if (snk_tready) begin
      vld_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      data_q <= load_data;
    end
  end

  assign snk_tvalid = vld_q;
  assign snk_tdata  = data_q;

endmodule

//--- verilog/source_fork.sv
`timescale 1ns/1ps

module source_fork
  import xbar_stream_pkg::*;
(
  input  src_mask_t                   src_tvalid,
  input  sink_mask_t [NUM_ACCS-1:0]   src_users,
  input  sink_mask_t                  space,
  output src_mask_t                   src_tready,
  output src_mask_t                   src_fire
);

  src_mask_t  has_user;
  src_mask_t  all_space;

  // a source only moves when every sink that selects it can take the beat,
  // so a broadcast beat lands in all of its sinks on the same edge.
  always_comb begin
    for (int a = 0; a < NUM_ACCS; a++) begin
      has_user[a]  = |src_users[a];
      all_space[a] = &(space | ~src_users[a]); // unselected sinks do not block.
    end
  end

  assign src_tready = has_user & all_space;     // low with no sink attached.
  assign src_fire   = src_tready & src_tvalid;

endmodule

//--- verilog/xbar_conf_pkg.sv
package xbar_conf_pkg;

  import xbar_stream_pkg::*;

  localparam int SEL_W = 4;

  // select code per sink.
  // 0 is idle, 1..NUM_ACCS picks source (code - 1), larger codes read as idle.
  typedef logic [SEL_W-1:0] sel_t;

  localparam sel_t SEL_IDLE = sel_t'(0);

  // decoded select of one sink, one bit per source.
  typedef logic [NUM_ACCS-1:0] src_onehot_t;

endpackage

//--- verilog/xbar_stream_pkg.sv
package xbar_stream_pkg;

  // sink = 2 * accelerator + port, with port A = 0 and port B = 1.

  localparam int NUM_ACCS  = 4;            // accelerators, one result stream each.
  localparam int NUM_SINKS = 2 * NUM_ACCS; // operand streams A and B per accelerator.
  localparam int DATA_W    = 32;

  // one stream beat.
  typedef logic [DATA_W-1:0] data_t;

  // one bit per source stream.
  typedef logic [NUM_ACCS-1:0] src_mask_t;

  // one bit per sink stream.
  typedef logic [NUM_SINKS-1:0] sink_mask_t;

endpackage
